// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ----------------------------------------
// widths
// ----------------------------------------

// data path and instruction word
`define RV_XLEN          32
`define RV_ILEN          32

// register index, 32 architectural registers
`define RV_RF_ADDR_W     5

// ----------------------------------------
// reset behaviour
// ----------------------------------------

// fetch starts one word in
`define RV_RESET_VECTOR  32'h0000_0004

// stage registers flushed after reset, one per cycle
`define RV_RST_SEQ_LEN   4

// ----------------------------------------
// opcodes of the supported subset
// ----------------------------------------
`define RV_OPC_OP        7'b0110011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_LUI       7'b0110111
`define RV_OPC_AUIPC     7'b0010111

`endif

// ==== verilog/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

    // ----------------------------------------
    // plain vectors
    // ----------------------------------------
    typedef logic [`RV_XLEN-1:0]      arch_word_t;
    typedef logic [`RV_ILEN-1:0]      inst_word_t;
    typedef logic [`RV_RF_ADDR_W-1:0] rf_addr_t;

    // ----------------------------------------
    // control encodings
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui passes the immediate through
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic {
        ALU_A_RS1,
        ALU_A_PC
    } alu_a_sel_t;

    typedef enum logic {
        ALU_B_RS2,
        ALU_B_IMM
    } alu_b_sel_t;

    // where an operand comes from
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WBK
    } fwd_sel_t;

    // ----------------------------------------
    // stage payloads
    // ----------------------------------------
    typedef struct packed {
        rf_addr_t   rs1;
        rf_addr_t   rs2;
        rf_addr_t   rd;
        logic       rd_we;
        arch_word_t imm;
        alu_op_t    alu_op;
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
    } decoded_t;

    typedef struct packed {
        logic       valid;
        arch_word_t pc;
        inst_word_t inst;
        decoded_t   decoded;
        arch_word_t rs1_data;
        arch_word_t rs2_data;
    } exe_stage_t;

    // memory and writeback stages
    typedef struct packed {
        logic       valid;
        arch_word_t pc;
        inst_word_t inst;
        rf_addr_t   rd;
        logic       rd_we;
        arch_word_t result;
    } res_stage_t;

    // same layout as res_stage_t
    typedef struct packed {
        logic       valid;
        arch_word_t pc;
        inst_word_t inst;
        rf_addr_t   rd;
        logic       rd_we;
        arch_word_t value;
    } retire_t;

endpackage

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder (
    input  rv_pkg::inst_word_t inst_i,
    input  logic               valid_i,
    output rv_pkg::decoded_t   dec_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               alt;
    rv_pkg::arch_word_t imm_i_type;
    rv_pkg::arch_word_t imm_u_type;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    // bit 30 selects sub and sra
    assign alt    = inst_i[30];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'h000};

    // funct3 to ALU op, sub only exists in the register form
    function automatic rv_pkg::alu_op_t f3_to_op(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       is_reg
    );
        rv_pkg::alu_op_t op;
        op = rv_pkg::ALU_ADD;
        case (f3)
            3'b000: op = (alt_bit && is_reg) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001: op = rv_pkg::ALU_SLL;
            3'b010: op = rv_pkg::ALU_SLT;
            3'b011: op = rv_pkg::ALU_SLTU;
            3'b100: op = rv_pkg::ALU_XOR;
            3'b101: op = alt_bit ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110: op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec_o.rs1       = '0;
        dec_o.rs2       = '0;
        dec_o.rd        = inst_i[11:7];
        dec_o.rd_we     = 1'b0;
        dec_o.imm       = '0;
        dec_o.alu_op    = rv_pkg::ALU_ADD;
        dec_o.alu_a_sel = rv_pkg::ALU_A_RS1;
        dec_o.alu_b_sel = rv_pkg::ALU_B_RS2;
        case (opcode)
            `RV_OPC_OP: begin
                dec_o.rs1    = inst_i[19:15];
                dec_o.rs2    = inst_i[24:20];
                dec_o.rd_we  = 1'b1;
                dec_o.alu_op = f3_to_op(funct3, alt, 1'b1);
            end
            `RV_OPC_OP_IMM: begin
                dec_o.rs1       = inst_i[19:15];
                dec_o.rd_we     = 1'b1;
                dec_o.imm       = imm_i_type;
                dec_o.alu_op    = f3_to_op(funct3, alt, 1'b0);
                dec_o.alu_b_sel = rv_pkg::ALU_B_IMM;
            end
            `RV_OPC_LUI: begin
                dec_o.rd_we     = 1'b1;
                dec_o.imm       = imm_u_type;
                dec_o.alu_op    = rv_pkg::ALU_PASS_B;
                dec_o.alu_b_sel = rv_pkg::ALU_B_IMM;
            end
            `RV_OPC_AUIPC: begin
                dec_o.rd_we     = 1'b1;
                dec_o.imm       = imm_u_type;
                dec_o.alu_a_sel = rv_pkg::ALU_A_PC;
                dec_o.alu_b_sel = rv_pkg::ALU_B_IMM;
            end
            default: begin
                // unsupported opcode retires without a write
                dec_o.rd_we = 1'b0;
            end
        endcase
        // bubbles and x0 never write
        if (!valid_i || dec_o.rd == '0) begin
            dec_o.rd_we = 1'b0;
        end
    end

endmodule

// ==== verilog/rv_reg_file.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               we_i,
    input  rv_pkg::rf_addr_t   waddr_i,
    input  rv_pkg::arch_word_t wdata_i,
    input  rv_pkg::rf_addr_t   raddr_a_i,
    input  rv_pkg::rf_addr_t   raddr_b_i,
    output rv_pkg::arch_word_t rdata_a_o,
    output rv_pkg::arch_word_t rdata_b_o
);

    localparam int unsigned NUM_REGS = 1 << `RV_RF_ADDR_W;

    // x0 has no storage
    rv_pkg::arch_word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read, same-cycle writes are covered by forwarding
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    // the decoder never lets a write to x0 reach writeback
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst) we_i |-> waddr_i != '0
    ) else $error("reg file: write to x0");

endmodule

// ==== verilog/rv_operand_fwd.sv ====
`timescale 1ns/1ps

module rv_operand_fwd (
    input  rv_pkg::rf_addr_t   dec_rs1_i,
    input  rv_pkg::rf_addr_t   dec_rs2_i,
    input  rv_pkg::arch_word_t rf_a_i,
    input  rv_pkg::arch_word_t rf_b_i,
    input  rv_pkg::exe_stage_t exe_i,
    input  rv_pkg::res_stage_t mem_i,
    input  rv_pkg::res_stage_t wbk_i,
    output rv_pkg::arch_word_t dec_a_o,
    output rv_pkg::arch_word_t dec_b_o,
    output rv_pkg::arch_word_t exe_a_o,
    output rv_pkg::arch_word_t exe_b_o
);

    rv_pkg::fwd_sel_t dec_a_sel;
    rv_pkg::fwd_sel_t dec_b_sel;
    rv_pkg::fwd_sel_t exe_a_sel;
    rv_pkg::fwd_sel_t exe_b_sel;

    // stage is about to write src, x0 excluded
    function automatic logic hits(input rv_pkg::res_stage_t st, input rv_pkg::rf_addr_t src);
        return st.valid && st.rd_we && (st.rd != '0) && (st.rd == src);
    endfunction

    // memory holds the younger result
    function automatic rv_pkg::fwd_sel_t exe_pick(input rv_pkg::rf_addr_t src);
        rv_pkg::fwd_sel_t sel;
        sel = rv_pkg::FWD_NONE;
        if (hits(mem_i, src)) begin
            sel = rv_pkg::FWD_MEM;
        end else if (hits(wbk_i, src)) begin
            sel = rv_pkg::FWD_WBK;
        end
        return sel;
    endfunction

    function automatic rv_pkg::arch_word_t pick_data(
        input rv_pkg::fwd_sel_t   sel,
        input rv_pkg::arch_word_t reg_data
    );
        rv_pkg::arch_word_t data;
        case (sel)
            rv_pkg::FWD_MEM: data = mem_i.result;
            rv_pkg::FWD_WBK: data = wbk_i.result;
            default:         data = reg_data;
        endcase
        return data;
    endfunction

    // decode side only sees writeback, the write lands at this same edge
    assign dec_a_sel = hits(wbk_i, dec_rs1_i) ? rv_pkg::FWD_WBK : rv_pkg::FWD_NONE;
    assign dec_b_sel = hits(wbk_i, dec_rs2_i) ? rv_pkg::FWD_WBK : rv_pkg::FWD_NONE;
    assign exe_a_sel = exe_pick(exe_i.decoded.rs1);
    assign exe_b_sel = exe_pick(exe_i.decoded.rs2);

    assign dec_a_o = pick_data(dec_a_sel, rf_a_i);
    assign dec_b_o = pick_data(dec_b_sel, rf_b_i);
    assign exe_a_o = pick_data(exe_a_sel, exe_i.rs1_data);
    assign exe_b_o = pick_data(exe_b_sel, exe_i.rs2_data);

endmodule

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t    op_i,
    input  rv_pkg::alu_a_sel_t a_sel_i,
    input  rv_pkg::alu_b_sel_t b_sel_i,
    input  rv_pkg::arch_word_t rs1_i,
    input  rv_pkg::arch_word_t rs2_i,
    input  rv_pkg::arch_word_t pc_i,
    input  rv_pkg::arch_word_t imm_i,
    output rv_pkg::arch_word_t result_o
);

    rv_pkg::arch_word_t a;
    rv_pkg::arch_word_t b;
    logic [4:0]         shamt;

    // auipc takes the pc, immediates replace rs2
    assign a = (a_sel_i == rv_pkg::ALU_A_PC) ? pc_i : rs1_i;
    assign b = (b_sel_i == rv_pkg::ALU_B_IMM) ? imm_i : rs2_i;

    assign shamt = b[4:0];

    always_comb begin
        unique case (op_i)
            rv_pkg::ALU_ADD:    result_o = a + b;
            rv_pkg::ALU_SUB:    result_o = a - b;
            rv_pkg::ALU_SLL:    result_o = a << shamt;
            rv_pkg::ALU_SLT:    result_o = rv_pkg::arch_word_t'($signed(a) < $signed(b));
            rv_pkg::ALU_SLTU:   result_o = rv_pkg::arch_word_t'(a < b);
            rv_pkg::ALU_XOR:    result_o = a ^ b;
            rv_pkg::ALU_SRL:    result_o = a >> shamt;
            rv_pkg::ALU_SRA:    result_o = rv_pkg::arch_word_t'($signed(a) >>> shamt);
            rv_pkg::ALU_OR:     result_o = a | b;
            rv_pkg::ALU_AND:    result_o = a & b;
            rv_pkg::ALU_PASS_B: result_o = b;
            default:            result_o = '0;
        endcase
    end

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
    input  logic               clk,
    input  logic               rst,
    output rv_pkg::arch_word_t imem_addr_o,
    input  rv_pkg::inst_word_t imem_data_i,
    input  logic               imem_valid_i,
    output rv_pkg::retire_t    retire_o
);

    // one flush bit per stage register behind decode
    logic [`RV_RST_SEQ_LEN-1:0] rst_seq;
    logic                       flush_exe;
    logic                       flush_mem;
    logic                       flush_wbk;
    logic                       flush_ret;

    rv_pkg::arch_word_t pc_q;

    logic               dec_valid_q;
    rv_pkg::arch_word_t dec_pc_q;
    rv_pkg::inst_word_t dec_inst_q;
    rv_pkg::decoded_t   dec;
    rv_pkg::arch_word_t rf_a;
    rv_pkg::arch_word_t rf_b;
    rv_pkg::arch_word_t dec_a;
    rv_pkg::arch_word_t dec_b;

    rv_pkg::exe_stage_t exe_d;
    rv_pkg::exe_stage_t exe_q;
    rv_pkg::arch_word_t exe_a;
    rv_pkg::arch_word_t exe_b;
    rv_pkg::arch_word_t exe_result;

    rv_pkg::res_stage_t mem_d;
    rv_pkg::res_stage_t mem_q;
    rv_pkg::res_stage_t wbk_q;
    rv_pkg::retire_t    ret_q;

    // a flushed slot keeps its payload but can neither retire nor write
    function automatic rv_pkg::res_stage_t kill_res(input rv_pkg::res_stage_t s, input logic kill);
        rv_pkg::res_stage_t r;
        r = s;
        if (kill) begin
            r.valid = 1'b0;
            r.rd_we = 1'b0;
        end
        return r;
    endfunction

    // ----------------------------------------
    // reset sequence and fetch
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rst_seq <= '1;
        end else begin
            rst_seq <= {rst_seq[`RV_RST_SEQ_LEN-2:0], 1'b0};
        end
    end

    assign flush_exe = rst_seq[0];
    assign flush_mem = rst_seq[1];
    assign flush_wbk = rst_seq[2];
    assign flush_ret = rst_seq[3];

    // pc only moves when the word was taken
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `RV_RESET_VECTOR;
        end else if (imem_valid_i) begin
            pc_q <= pc_q + 'd4;
        end
    end

    assign imem_addr_o = pc_q;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= imem_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_valid_i) begin
            dec_pc_q   <= pc_q;
            dec_inst_q <= imem_data_i;
        end
    end

    rv_decoder u_decoder (
        .inst_i  (dec_inst_q),
        .valid_i (dec_valid_q),
        .dec_o   (dec)
    );

    rv_reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .we_i      (wbk_q.valid && wbk_q.rd_we),
        .waddr_i   (wbk_q.rd),
        .wdata_i   (wbk_q.result),
        .raddr_a_i (dec.rs1),
        .raddr_b_i (dec.rs2),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    rv_operand_fwd u_operand_fwd (
        .dec_rs1_i (dec.rs1),
        .dec_rs2_i (dec.rs2),
        .rf_a_i    (rf_a),
        .rf_b_i    (rf_b),
        .exe_i     (exe_q),
        .mem_i     (mem_q),
        .wbk_i     (wbk_q),
        .dec_a_o   (dec_a),
        .dec_b_o   (dec_b),
        .exe_a_o   (exe_a),
        .exe_b_o   (exe_b)
    );

    assign exe_d = '{valid: dec_valid_q, pc: dec_pc_q, inst: dec_inst_q,
                     decoded: dec, rs1_data: dec_a, rs2_data: dec_b};

    always_ff @(posedge clk) begin
        exe_q <= exe_d;
        if (rst || flush_exe) begin
            exe_q.valid         <= 1'b0;
            exe_q.decoded.rd_we <= 1'b0;
        end
    end

    // ----------------------------------------
    // execute, memory, writeback, retire
    // ----------------------------------------
    rv_alu u_alu (
        .op_i     (exe_q.decoded.alu_op),
        .a_sel_i  (exe_q.decoded.alu_a_sel),
        .b_sel_i  (exe_q.decoded.alu_b_sel),
        .rs1_i    (exe_a),
        .rs2_i    (exe_b),
        .pc_i     (exe_q.pc),
        .imm_i    (exe_q.decoded.imm),
        .result_o (exe_result)
    );

    assign mem_d = '{valid: exe_q.valid, pc: exe_q.pc, inst: exe_q.inst,
                     rd: exe_q.decoded.rd, rd_we: exe_q.decoded.rd_we, result: exe_result};

    // memory stage has no access, it only delays the result by one cycle
    always_ff @(posedge clk) begin
        mem_q <= kill_res(mem_d, rst || flush_mem);
        wbk_q <= kill_res(mem_q, rst || flush_wbk);
        ret_q <= rv_pkg::retire_t'(kill_res(wbk_q, rst || flush_ret));
    end

    assign retire_o = ret_q;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) imem_addr_o[1:0] == 2'b00
    ) else $error("core: fetch pc not word aligned");

    // retire_o is written four edges after the take and seen one edge later
    a_retire_latency: assert property (
        @(posedge clk) disable iff (rst) retire_o.valid |-> $past(imem_valid_i, 5)
    ) else $error("core: retire without a matching fetch");

endmodule

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DLY      = 10;
    localparam int RST_CYCLES     = 2;
    localparam int SEED           = 63;
    localparam int PROG_LEN       = 120;
    localparam int RETIRE_LAT     = 4;
    localparam int TIMEOUT_MARGIN = 50;

    // addi x0, x0, 0 served past the end of the program
    localparam rv_pkg::inst_word_t NOP_WORD = {12'h000, 5'd0, 3'b000, 5'd0, `RV_OPC_OP_IMM};

    logic               clk;
    logic               rst;
    rv_pkg::inst_word_t imem_data_i;
    logic               imem_valid_i;
    rv_pkg::arch_word_t imem_addr_o;
    rv_pkg::retire_t    retire_o;

    rv_pkg::inst_word_t prog [0:127];

    // architectural model, updated in retire order
    rv_pkg::arch_word_t model [0:31];
    int                 last_wr [0:31];
    int                 take_cyc [0:255];

    int                 cyc = 0;
    int                 taken_cnt = 0;
    int                 retired_cnt = 0;
    int                 gap_cnt = 0;
    int                 dep_cnt [1:3] = '{0, 0, 0};
    int                 x0_wr_cnt = 0;
    int                 x0_rd_cnt = 0;
    rv_pkg::arch_word_t next_pc = `RV_RESET_VECTOR;

    int                 fail_reset = 0;
    int                 fail_order = 0;
    int                 fail_value = 0;
    int                 fail_fwd = 0;
    int                 fail_x0 = 0;

    rv_pkg::arch_word_t fetch_off;
    rv_pkg::arch_word_t ret_off;
    rv_pkg::inst_word_t exp_inst;
    logic [4:0]         ret_rd;
    logic [4:0]         ret_rs1;
    logic [4:0]         ret_rs2;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               exp_we;
    rv_pkg::arch_word_t exp_value;
    int                 dep_dist;
    int                 ret_age;

    rv_core DUT (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .imem_valid_i (imem_valid_i),
        .retire_o     (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // program and reference
    // ----------------------------------------
    function automatic rv_pkg::inst_word_t random_inst();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        kind = $urandom_range(0, 9);
        // few registers, so dependencies come often
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        f7   = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        imm  = 12'($urandom);
        if (kind < 4) begin
            // alternate funct7 only for sub and sra
            if (f3 != 3'b000 && f3 != 3'b101) begin
                f7 = 7'h00;
            end
            return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
        end
        if (kind < 8) begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm = {(f3 == 3'b101) ? f7 : 7'h00, imm[4:0]};
            end
            return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
        end
        if (kind == 8) begin
            return {20'($urandom), rd, `RV_OPC_LUI};
        end
        return {20'($urandom), rd, `RV_OPC_AUIPC};
    endfunction

    function automatic rv_pkg::inst_word_t word_at(input rv_pkg::arch_word_t addr);
        rv_pkg::arch_word_t off;
        off = addr - `RV_RESET_VECTOR;
        if ((off >> 2) < 32'(PROG_LEN)) begin
            return prog[off[8:2]];
        end
        return NOP_WORD;
    endfunction

    // RV32I result for the supported opcodes
    function automatic rv_pkg::arch_word_t isa_result(
        input rv_pkg::inst_word_t inst,
        input rv_pkg::arch_word_t pc,
        input rv_pkg::arch_word_t src1,
        input rv_pkg::arch_word_t src2
    );
        rv_pkg::arch_word_t upper;
        rv_pkg::arch_word_t opnd;
        rv_pkg::arch_word_t sra_val;
        logic               is_reg;
        rv_pkg::arch_word_t res;
        upper  = {inst[31:12], 12'h000};
        is_reg = (inst[6:0] == `RV_OPC_OP);
        opnd   = is_reg ? src2 : {{20{inst[31]}}, inst[31:20]};
        sra_val = $signed(src1) >>> opnd[4:0];
        res    = '0;
        if (inst[6:0] == `RV_OPC_LUI) begin
            res = upper;
        end else if (inst[6:0] == `RV_OPC_AUIPC) begin
            res = pc + upper;
        end else begin
            case (inst[14:12])
                3'b000: res = (is_reg && inst[30]) ? src1 - opnd : src1 + opnd;
                3'b001: res = src1 << opnd[4:0];
                3'b010: res = {31'b0, $signed(src1) < $signed(opnd)};
                3'b011: res = {31'b0, src1 < opnd};
                3'b100: res = src1 ^ opnd;
                3'b101: res = inst[30] ? sra_val : src1 >> opnd[4:0];
                3'b110: res = src1 | opnd;
                default: res = src1 & opnd;
            endcase
        end
        return res;
    endfunction

    assign fetch_off = imem_addr_o - `RV_RESET_VECTOR;
    assign ret_off   = next_pc - `RV_RESET_VECTOR;

    // expectations come from the program word at the next pc in order
    always_comb begin
        exp_inst  = word_at(next_pc);
        ret_rd    = exp_inst[11:7];
        ret_rs1   = exp_inst[19:15];
        ret_rs2   = exp_inst[24:20];
        uses_rs1  = exp_inst[6:0] inside {`RV_OPC_OP, `RV_OPC_OP_IMM};
        uses_rs2  = exp_inst[6:0] == `RV_OPC_OP;
        exp_we    = (ret_rd != 5'd0);
        exp_value = isa_result(exp_inst, next_pc,
                               uses_rs1 ? model[ret_rs1] : '0,
                               uses_rs2 ? model[ret_rs2] : '0);
        ret_age   = cyc - take_cyc[ret_off[9:2]];
        // nearest producer in program order, 0 when none within 3
        dep_dist  = 0;
        for (int d = 3; d >= 1; d--) begin
            if ((uses_rs1 && ret_rs1 != 5'd0 && retired_cnt - last_wr[ret_rs1] == d) ||
                (uses_rs2 && ret_rs2 != 5'd0 && retired_cnt - last_wr[ret_rs2] == d)) begin
                dep_dist = d;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst && imem_valid_i) begin
            take_cyc[fetch_off[9:2]] <= cyc;
            taken_cnt <= taken_cnt + 1;
        end
        if (!rst && !imem_valid_i) begin
            gap_cnt <= gap_cnt + 1;
        end
        if (!rst && retire_o.valid) begin
            if (exp_we) begin
                model[ret_rd]   <= exp_value;
                last_wr[ret_rd] <= retired_cnt;
            end else begin
                x0_wr_cnt <= x0_wr_cnt + 1;
            end
            if (x0_wr_cnt > 0 && ((uses_rs1 && ret_rs1 == 5'd0) ||
                                  (uses_rs2 && ret_rs2 == 5'd0))) begin
                x0_rd_cnt <= x0_rd_cnt + 1;
            end
            if (dep_dist != 0) begin
                dep_cnt[dep_dist] <= dep_cnt[dep_dist] + 1;
            end
            retired_cnt <= retired_cnt + 1;
            next_pc     <= next_pc + 32'd4;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !retire_o.valid)
        else begin
            fail_reset++;
            $display("retire reported during reset at %0t", $time);
        end

    a_none_before_take: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid |-> taken_cnt > retired_cnt)
        else begin
            fail_reset++;
            $display("retire at %0t with no instruction taken for it", $time);
        end

    a_first_pc: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid && retired_cnt == 0 |-> retire_o.pc == `RV_RESET_VECTOR)
        else begin
            fail_reset++;
            $display("mismatch at %0t: first retired pc %h", $time, $sampled(retire_o.pc));
        end

    a_pc_order: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid |-> retire_o.pc == next_pc)
        else begin
            fail_order++;
            $display("mismatch at %0t: retired pc %h, expected %h", $time,
                     $sampled(retire_o.pc), $sampled(next_pc));
        end

    a_inst: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid |-> retire_o.inst == exp_inst)
        else begin
            fail_order++;
            $display("mismatch at %0t: pc %h instruction %h, expected %h", $time,
                     $sampled(retire_o.pc), $sampled(retire_o.inst), $sampled(exp_inst));
        end

    // seen one edge after retire_o is written
    a_latency: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid |-> ret_age == RETIRE_LAT + 1)
        else begin
            fail_order++;
            $display("mismatch at %0t: pc %h retired %0d edges after take", $time,
                     $sampled(retire_o.pc), $sampled(ret_age) - 1);
        end

    a_dest: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid && exp_we |-> retire_o.rd_we && retire_o.rd == ret_rd)
        else begin
            fail_value++;
            $display("mismatch at %0t: pc %h destination x%0d write %b", $time,
                     $sampled(retire_o.pc), $sampled(retire_o.rd), $sampled(retire_o.rd_we));
        end

    a_value: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid && dep_dist == 0 |-> retire_o.value == exp_value)
        else begin
            fail_value++;
            $display("mismatch at %0t: pc %h value %h, expected %h", $time,
                     $sampled(retire_o.pc), $sampled(retire_o.value), $sampled(exp_value));
        end

    a_fwd_value: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid && dep_dist != 0 |-> retire_o.value == exp_value)
        else begin
            fail_fwd++;
            $display("mismatch at %0t: pc %h distance %0d value %h, expected %h", $time,
                     $sampled(retire_o.pc), $sampled(dep_dist), $sampled(retire_o.value),
                     $sampled(exp_value));
        end

    a_x0_write: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid && ret_rd == 5'd0 |-> !retire_o.rd_we)
        else begin
            fail_x0++;
            $display("mismatch at %0t: pc %h writes x0", $time, $sampled(retire_o.pc));
        end

    // ----------------------------------------
    // stimulus and reporting
    // ----------------------------------------
    task automatic drive_fetch();
        imem_valid_i = ($urandom_range(0, 3) != 0);
        imem_data_i  = word_at(imem_addr_o);
    endtask

    task automatic report_tests();
        int holes;
        int total;
        holes = 0;
        if (gap_cnt == 0) begin
            $display("fetch never stalled, so retire order under gaps was not exercised");
            holes++;
        end
        for (int d = 1; d <= 3; d++) begin
            if (dep_cnt[d] == 0) begin
                $display("no dependent instruction at distance %0d was retired", d);
                holes++;
            end
        end
        if (x0_wr_cnt == 0 || x0_rd_cnt == 0) begin
            $display("writes to x0 followed by reads of x0 were not exercised");
            holes++;
        end
        $display("test 1 reset and first retire: %0d failures", fail_reset);
        $display("test 2 order and latency, %0d gaps: %0d failures", gap_cnt, fail_order);
        $display("test 3 results: %0d failures", fail_value);
        $display("test 4 forwarding d1=%0d d2=%0d d3=%0d: %0d failures",
                 dep_cnt[1], dep_cnt[2], dep_cnt[3], fail_fwd);
        $display("test 5 x0 writes=%0d reads=%0d: %0d failures", x0_wr_cnt, x0_rd_cnt, fail_x0);
        total = fail_reset + fail_order + fail_value + fail_fwd + fail_x0;
        $display("summary: %0d retired, %0d check failures, %0d coverage holes",
                 retired_cnt, total, holes);
        if (total == 0 && holes == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
    endtask

    initial begin
        rst          = 1'b1;
        imem_valid_i = 1'b0;
        imem_data_i  = '0;
        void'($urandom(SEED));
        for (int i = 0; i < 32; i++) begin
            model[i]   = '0;
            last_wr[i] = -10;
        end
        for (int i = 0; i < 256; i++) begin
            take_cyc[i] = 0;
        end
        for (int i = 0; i < 128; i++) begin
            prog[i] = (i < PROG_LEN) ? random_inst() : NOP_WORD;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        drive_fetch();
        while (retired_cnt < PROG_LEN) begin
            @(posedge clk);
            #DRIVE_DLY;
            drive_fetch();
        end
        report_tests();
        $finish;
    end

    // about four cycles per instruction is far more than gaps need
    initial begin
        #(CLK_PERIOD * (RST_CYCLES + PROG_LEN * 4 + TIMEOUT_MARGIN));
        $display("timeout: only %0d of %0d instructions retired", retired_cnt, PROG_LEN);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_reg_file.sv
verilog/rv_operand_fwd.sv
verilog/rv_alu.sv
verilog/rv_core.sv
tests/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_rv_core \
    -Mdir "$OBJ" -o tb_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/tb_rv_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
